// File: rtl/cpu_pkg.sv
package cpu_pkg;

    typedef logic [7:0]  byte_t;    // Data bus value
    typedef logic [15:0] addr_t;    // Address bus value
    typedef logic [2:0]  cond_t;    // Branch condition, opcode bits 7:5

    // Sequencer states, one path per addressing mode
    typedef enum logic [5:0] {
        BRA0   = 6'd5,              // Offset to ALU (+PCL)
        BRA1   = 6'd6,              // Fetch target opcode, PCH to ALU
        BRA2   = 6'd7,              // Refetch after page crossing
        DECODE = 6'd12,             // Opcode valid, commit previous result
        FETCH  = 6'd13,             // Fetch next opcode, run ALU op
        JMP0   = 6'd22,             // Fetch low byte
        JMP1   = 6'd23,             // Fetch high byte
        REG    = 6'd36,             // Register to register ops
        ZP0    = 6'd47              // Zero-page read or write
    } state_e;

    typedef enum logic [2:0] {
        OP_ADD  = 3'b001,
        OP_SUB  = 3'b011,           // Add of inverted operand
        OP_OR   = 3'b100,
        OP_AND  = 3'b101,
        OP_EOR  = 3'b110,
        OP_PASS = 3'b111            // AI straight through
    } alu_op_e;

    localparam byte_t ZERO_PAGE = 8'h00;

    localparam byte_t OPC_LDA_IMM = 8'hA9;
    localparam byte_t OPC_LDA_ZP  = 8'hA5;
    localparam byte_t OPC_LDX_IMM = 8'hA2;
    localparam byte_t OPC_LDX_ZP  = 8'hA6;
    localparam byte_t OPC_ADC_IMM = 8'h69;
    localparam byte_t OPC_ADC_ZP  = 8'h65;
    localparam byte_t OPC_SBC_IMM = 8'hE9;
    localparam byte_t OPC_SBC_ZP  = 8'hE5;
    localparam byte_t OPC_AND_IMM = 8'h29;
    localparam byte_t OPC_AND_ZP  = 8'h25;
    localparam byte_t OPC_ORA_IMM = 8'h09;
    localparam byte_t OPC_ORA_ZP  = 8'h05;
    localparam byte_t OPC_EOR_IMM = 8'h49;
    localparam byte_t OPC_EOR_ZP  = 8'h45;
    localparam byte_t OPC_CMP_IMM = 8'hC9;
    localparam byte_t OPC_CMP_ZP  = 8'hC5;
    localparam byte_t OPC_STA_ZP  = 8'h85;
    localparam byte_t OPC_STX_ZP  = 8'h86;
    localparam byte_t OPC_TAX     = 8'hAA;
    localparam byte_t OPC_TXA     = 8'h8A;
    localparam byte_t OPC_INX     = 8'hE8;
    localparam byte_t OPC_DEX     = 8'hCA;
    localparam byte_t OPC_CLC     = 8'h18;
    localparam byte_t OPC_SEC     = 8'h38;
    localparam byte_t OPC_BPL     = 8'h10;
    localparam byte_t OPC_BMI     = 8'h30;
    localparam byte_t OPC_BCC     = 8'h90;
    localparam byte_t OPC_BCS     = 8'hB0;
    localparam byte_t OPC_BNE     = 8'hD0;
    localparam byte_t OPC_BEQ     = 8'hF0;
    localparam byte_t OPC_JMP_ABS = 8'h4C;

endpackage

// File: rtl/cpu_decode.sv
module cpu_decode (
    input  logic             clk,
    input  logic             reset,
    input  logic             decode_en,
    input  cpu_pkg::byte_t   ir,
    output cpu_pkg::state_e  next_state,
    output cpu_pkg::alu_op_e alu_op,
    output logic             load_reg,
    output logic             dst_x,
    output logic             src_x,
    output logic             store,
    output logic             load_only,
    output logic             compare,
    output logic             adc_sbc,
    output logic             set_c,
    output logic             clr_c,
    output cpu_pkg::cond_t   cond
);

    // Opcode group matches, immediate and zero page together
    wire is_lda = (ir == cpu_pkg::OPC_LDA_IMM) || (ir == cpu_pkg::OPC_LDA_ZP);
    wire is_ldx = (ir == cpu_pkg::OPC_LDX_IMM) || (ir == cpu_pkg::OPC_LDX_ZP);
    wire is_adc = (ir == cpu_pkg::OPC_ADC_IMM) || (ir == cpu_pkg::OPC_ADC_ZP);
    wire is_sbc = (ir == cpu_pkg::OPC_SBC_IMM) || (ir == cpu_pkg::OPC_SBC_ZP);
    wire is_and = (ir == cpu_pkg::OPC_AND_IMM) || (ir == cpu_pkg::OPC_AND_ZP);
    wire is_ora = (ir == cpu_pkg::OPC_ORA_IMM) || (ir == cpu_pkg::OPC_ORA_ZP);
    wire is_eor = (ir == cpu_pkg::OPC_EOR_IMM) || (ir == cpu_pkg::OPC_EOR_ZP);
    wire is_cmp = (ir == cpu_pkg::OPC_CMP_IMM) || (ir == cpu_pkg::OPC_CMP_ZP);
    wire is_sta = ir == cpu_pkg::OPC_STA_ZP;
    wire is_stx = ir == cpu_pkg::OPC_STX_ZP;
    wire is_tax = ir == cpu_pkg::OPC_TAX;
    wire is_txa = ir == cpu_pkg::OPC_TXA;
    wire is_inx = ir == cpu_pkg::OPC_INX;
    wire is_dex = ir == cpu_pkg::OPC_DEX;

    cpu_pkg::alu_op_e op_d;

    always_comb begin
        op_d = cpu_pkg::OP_PASS;                        // TAX, TXA, flag ops, NOP
        if (is_lda || is_ldx || is_adc || is_inx)
            op_d = cpu_pkg::OP_ADD;                     // Loads add to zero AI
        if (is_sbc || is_cmp || is_dex)
            op_d = cpu_pkg::OP_SUB;
        if (is_and)
            op_d = cpu_pkg::OP_AND;
        if (is_ora)
            op_d = cpu_pkg::OP_OR;
        if (is_eor)
            op_d = cpu_pkg::OP_EOR;
    end

    // Entry state of each addressing path
    always_comb begin
        case (ir)
            cpu_pkg::OPC_LDA_IMM, cpu_pkg::OPC_LDX_IMM, cpu_pkg::OPC_ADC_IMM,
            cpu_pkg::OPC_SBC_IMM, cpu_pkg::OPC_AND_IMM, cpu_pkg::OPC_ORA_IMM,
            cpu_pkg::OPC_EOR_IMM, cpu_pkg::OPC_CMP_IMM:
                next_state = cpu_pkg::FETCH;            // Operand is next byte
            cpu_pkg::OPC_LDA_ZP, cpu_pkg::OPC_LDX_ZP, cpu_pkg::OPC_ADC_ZP,
            cpu_pkg::OPC_SBC_ZP, cpu_pkg::OPC_AND_ZP, cpu_pkg::OPC_ORA_ZP,
            cpu_pkg::OPC_EOR_ZP, cpu_pkg::OPC_CMP_ZP, cpu_pkg::OPC_STA_ZP,
            cpu_pkg::OPC_STX_ZP:
                next_state = cpu_pkg::ZP0;
            cpu_pkg::OPC_BPL, cpu_pkg::OPC_BMI, cpu_pkg::OPC_BCC,
            cpu_pkg::OPC_BCS, cpu_pkg::OPC_BNE, cpu_pkg::OPC_BEQ:
                next_state = cpu_pkg::BRA0;
            cpu_pkg::OPC_JMP_ABS:
                next_state = cpu_pkg::JMP0;
            default:
                next_state = cpu_pkg::REG;              // Implied, unknown ones as NOP
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            alu_op    <= cpu_pkg::OP_PASS;
            load_reg  <= 1'b0;
            dst_x     <= 1'b0;
            src_x     <= 1'b0;
            store     <= 1'b0;
            load_only <= 1'b0;
            compare   <= 1'b0;
            adc_sbc   <= 1'b0;
            set_c     <= 1'b0;
            clr_c     <= 1'b0;
            cond      <= '0;
        end else if (decode_en) begin
            alu_op    <= op_d;
            load_reg  <= is_lda | is_ldx | is_adc | is_sbc | is_and | is_ora | is_eor
                         | is_tax | is_txa | is_inx | is_dex;
            dst_x     <= is_ldx | is_tax | is_inx | is_dex;
            src_x     <= is_stx | is_txa | is_inx | is_dex;
            store     <= is_sta | is_stx;
            load_only <= is_lda | is_ldx;
            compare   <= is_cmp;
            adc_sbc   <= is_adc | is_sbc;
            set_c     <= ir == cpu_pkg::OPC_SEC;
            clr_c     <= ir == cpu_pkg::OPC_CLC;
            cond      <= ir[7:5];                       // Flag select and sense
        end
    end

    // Immediate path entry never carries a captured store
    assert property (@(posedge clk) disable iff (reset)
        decode_en && (next_state == cpu_pkg::FETCH) |=> !store);

endmodule

// File: rtl/cpu_alu.sv
module cpu_alu (
    input  logic             clk,
    input  logic             reset,
    input  cpu_pkg::alu_op_e op,
    input  cpu_pkg::byte_t   ai,
    input  cpu_pkg::byte_t   bi,
    input  logic             ci,
    output cpu_pkg::byte_t   result,
    output logic             co,
    output logic             v,
    output logic             n,
    output logic             zero
);

    cpu_pkg::byte_t bi_eff;                 // B operand after subtract inversion
    logic [8:0]     sum;                    // Carry out in bit 8

    assign bi_eff = (op == cpu_pkg::OP_SUB) ? ~bi : bi;

    always_comb begin
        case (op)
            cpu_pkg::OP_OR:  sum = {1'b0, ai | bi};
            cpu_pkg::OP_AND: sum = {1'b0, ai & bi};
            cpu_pkg::OP_EOR: sum = {1'b0, ai ^ bi};
            cpu_pkg::OP_ADD,
            cpu_pkg::OP_SUB: sum = {1'b0, ai} + {1'b0, bi_eff} + {8'd0, ci};
            default:         sum = {1'b0, ai};         // Pass
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            result <= '0;
            co     <= 1'b0;
            v      <= 1'b0;
            n      <= 1'b0;
        end else begin
            result <= sum[7:0];
            co     <= sum[8];
            n      <= sum[7];
            // Carry into bit 7 differs from carry out
            v      <= ai[7] ^ bi_eff[7] ^ sum[8] ^ sum[7];
        end
    end

    assign zero = ~|result;

    // Op select comes from the sequencer mux, must stay resolved
    assert property (@(posedge clk) disable iff (reset) !$isunknown(op));

endmodule

// File: rtl/cpu_regs.sv
module cpu_regs (
    input  logic           clk,
    input  logic           reset,
    input  logic           commit,
    input  cpu_pkg::byte_t result,
    input  logic           co,
    input  logic           v_in,
    input  logic           n_in,
    input  logic           zero,
    input  logic           load_reg,
    input  logic           dst_x,
    input  logic           compare,
    input  logic           adc_sbc,
    input  logic           set_c,
    input  logic           clr_c,
    output cpu_pkg::byte_t a,
    output cpu_pkg::byte_t x,
    output logic           flag_n,
    output logic           flag_v,
    output logic           flag_z,
    output logic           flag_c
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            a      <= '0;
            x      <= '0;
            flag_n <= 1'b0;
            flag_v <= 1'b0;
            flag_z <= 1'b0;
            flag_c <= 1'b0;
        end else if (commit) begin
            if (load_reg && dst_x)
                x <= result;
            if (load_reg && !dst_x)
                a <= result;
            if (load_reg || compare) begin          // Loads, logic, arith, CMP
                flag_n <= n_in;
                flag_z <= zero;
            end
            if (adc_sbc || compare)
                flag_c <= co;                       // Borrow is inverted carry
            else if (set_c)
                flag_c <= 1'b1;
            else if (clr_c)
                flag_c <= 1'b0;
            if (adc_sbc)
                flag_v <= v_in;
        end
    end

    // CLC and SEC decode into separate bits, one instruction at a time
    assert property (@(posedge clk) disable iff (reset) !(set_c && clr_c));

endmodule

// File: rtl/cpu_sequencer.sv
module cpu_sequencer #(
    parameter cpu_pkg::addr_t RESET_PC = 16'h02C0
) (
    input  logic             clk,
    input  logic             reset,
    input  cpu_pkg::byte_t   din,
    input  cpu_pkg::state_e  next_state,
    output logic             decode_en,
    output logic             commit,
    input  logic             store,
    input  logic             load_only,
    input  logic             compare,
    input  logic             src_x,
    input  cpu_pkg::alu_op_e alu_op,
    output cpu_pkg::alu_op_e alu_op_cur,
    output cpu_pkg::byte_t   ai,
    output cpu_pkg::byte_t   bi,
    output logic             ci,
    input  cpu_pkg::byte_t   result,
    input  logic             co,
    input  cpu_pkg::byte_t   a,
    input  cpu_pkg::byte_t   x,
    input  logic             flag_n,
    input  logic             flag_v,
    input  logic             flag_z,
    input  logic             flag_c,
    input  cpu_pkg::cond_t   cond,
    output cpu_pkg::addr_t   addr,
    output cpu_pkg::byte_t   dout,
    output logic             we
);

    cpu_pkg::state_e state;
    cpu_pkg::addr_t  pc;
    cpu_pkg::addr_t  pc_temp;               // PC base before increment
    logic            pc_inc;
    cpu_pkg::addr_t  prev_addr;             // Last cycle's address bus
    cpu_pkg::byte_t  src_reg;
    logic            backwards;             // Branch offset sign
    logic            cond_true;

    assign decode_en = state == cpu_pkg::DECODE;
    assign commit    = state == cpu_pkg::DECODE;   // Previous op retires here
    assign src_reg   = src_x ? x : a;
    assign dout      = src_reg;
    assign we        = (state == cpu_pkg::ZP0) && store;

    always_comb begin
        case (cond)
            3'b000:  cond_true = ~flag_n;   // BPL
            3'b001:  cond_true = flag_n;    // BMI
            3'b010:  cond_true = ~flag_v;
            3'b011:  cond_true = flag_v;
            3'b100:  cond_true = ~flag_c;   // BCC
            3'b101:  cond_true = flag_c;    // BCS
            3'b110:  cond_true = ~flag_z;   // BNE
            default: cond_true = flag_z;    // BEQ
        endcase
    end

    always_comb begin
        pc_temp = pc;
        pc_inc  = 1'b0;
        case (state)
            cpu_pkg::DECODE, cpu_pkg::FETCH, cpu_pkg::BRA0: pc_inc = 1'b1;
            cpu_pkg::BRA1: begin
                pc_temp = {prev_addr[15:8], result};
                pc_inc  = co ~^ backwards;         // Target fetched unless page moved
            end
            cpu_pkg::BRA2: begin
                pc_temp = {result, pc[7:0]};
                pc_inc  = 1'b1;
            end
            cpu_pkg::JMP1: begin
                pc_temp = {din, result};
                pc_inc  = 1'b1;
            end
            default: ;                              // REG, ZP0, JMP0 hold PC
        endcase
    end

    always_comb begin
        case (state)
            cpu_pkg::ZP0:  addr = {cpu_pkg::ZERO_PAGE, din};
            cpu_pkg::REG:  addr = prev_addr;       // Refetch next opcode
            cpu_pkg::BRA1: addr = {prev_addr[15:8], result};
            cpu_pkg::BRA2: addr = {result, prev_addr[7:0]};
            cpu_pkg::JMP1: addr = {din, result};
            default:       addr = pc;
        endcase
    end

    // ALU operand muxes
    always_comb begin
        alu_op_cur = cpu_pkg::OP_ADD;
        ai         = '0;
        bi         = din;
        ci         = 1'b0;
        case (state)
            cpu_pkg::FETCH: begin
                alu_op_cur = alu_op;
                ai         = load_only ? 8'h00 : src_reg;
                ci         = compare ? 1'b1 : (load_only ? 1'b0 : flag_c);
            end
            cpu_pkg::REG: begin
                alu_op_cur = alu_op;
                ai         = src_reg;
                bi         = '0;
                ci         = alu_op == cpu_pkg::OP_ADD;   // INX adds one, DEX adds FF
            end
            cpu_pkg::BRA0: begin
                ai = din;                           // Offset + PCL
                bi = pc[7:0];
            end
            cpu_pkg::BRA1: begin
                alu_op_cur = backwards ? cpu_pkg::OP_SUB : cpu_pkg::OP_ADD;
                ai         = prev_addr[15:8];      // PCH fixup by carry
                bi         = '0;
                ci         = co;
            end
            default: ;                              // JMP0 latches low byte
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= cpu_pkg::FETCH;
            pc    <= RESET_PC;
        end else begin
            pc <= pc_temp + {15'd0, pc_inc};
            case (state)
                cpu_pkg::DECODE: state <= next_state;
                cpu_pkg::ZP0:    state <= cpu_pkg::FETCH;
                cpu_pkg::BRA0:   state <= cond_true ? cpu_pkg::BRA1 : cpu_pkg::DECODE;
                cpu_pkg::BRA1:   state <= (co ^ backwards) ? cpu_pkg::BRA2 : cpu_pkg::DECODE;
                cpu_pkg::JMP0:   state <= cpu_pkg::JMP1;
                default:         state <= cpu_pkg::DECODE;   // FETCH, REG, BRA2, JMP1
            endcase
        end
    end

    always_ff @(posedge clk) begin
        prev_addr <= addr;
        if (state == cpu_pkg::BRA0)
            backwards <= din[7];
    end

    // Store write is the cycle right after its decode, never with a load decoded
    assert property (@(posedge clk) disable iff (reset)
        we |-> $past(state == cpu_pkg::DECODE) && !load_only && !compare);

endmodule

// File: rtl/cpu_core.sv
module cpu_core #(
    parameter cpu_pkg::addr_t RESET_PC = 16'h02C0
) (
    input  logic           clk,
    input  logic           reset,
    output cpu_pkg::addr_t addr,
    input  cpu_pkg::byte_t din,
    output cpu_pkg::byte_t dout,
    output logic           we
);

    cpu_pkg::state_e  next_state;
    cpu_pkg::alu_op_e alu_op;
    cpu_pkg::alu_op_e alu_op_cur;
    cpu_pkg::cond_t   cond;
    cpu_pkg::byte_t   ai;
    cpu_pkg::byte_t   bi;
    cpu_pkg::byte_t   result;
    cpu_pkg::byte_t   a;
    cpu_pkg::byte_t   x;
    logic decode_en, commit;
    logic load_reg, dst_x, src_x, store, load_only, compare, adc_sbc, set_c, clr_c;
    logic ci, co, v, n, zero;
    logic flag_n, flag_v, flag_z, flag_c;

    cpu_sequencer #(.RESET_PC(RESET_PC)) u_sequencer (
        .clk(clk), .reset(reset), .din(din), .next_state(next_state),
        .decode_en(decode_en), .commit(commit),
        .store(store), .load_only(load_only), .compare(compare), .src_x(src_x),
        .alu_op(alu_op), .alu_op_cur(alu_op_cur), .ai(ai), .bi(bi), .ci(ci),
        .result(result), .co(co), .a(a), .x(x),
        .flag_n(flag_n), .flag_v(flag_v), .flag_z(flag_z), .flag_c(flag_c),
        .cond(cond), .addr(addr), .dout(dout), .we(we)
    );

    // Opcode arrives on din during DECODE
    cpu_decode u_decode (
        .clk(clk), .reset(reset), .decode_en(decode_en), .ir(din),
        .next_state(next_state), .alu_op(alu_op),
        .load_reg(load_reg), .dst_x(dst_x), .src_x(src_x), .store(store),
        .load_only(load_only), .compare(compare), .adc_sbc(adc_sbc),
        .set_c(set_c), .clr_c(clr_c), .cond(cond)
    );

    cpu_alu u_alu (
        .clk(clk), .reset(reset), .op(alu_op_cur), .ai(ai), .bi(bi), .ci(ci),
        .result(result), .co(co), .v(v), .n(n), .zero(zero)
    );

    cpu_regs u_regs (
        .clk(clk), .reset(reset), .commit(commit), .result(result),
        .co(co), .v_in(v), .n_in(n), .zero(zero),
        .load_reg(load_reg), .dst_x(dst_x), .compare(compare), .adc_sbc(adc_sbc),
        .set_c(set_c), .clr_c(clr_c), .a(a), .x(x),
        .flag_n(flag_n), .flag_v(flag_v), .flag_z(flag_z), .flag_c(flag_c)
    );

endmodule

// File: sim/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [31:0]    lfsr_state = 32'ha97890e3;
cpu_pkg::addr_t gen_pc;                         // Next free program byte
cpu_pkg::byte_t zp_mem [0:255];                 // Model copy of zero page
cpu_pkg::byte_t m_a, m_x;                       // Model registers
logic           m_n, m_v, m_z, m_c;
cpu_pkg::addr_t exp_addr[$];                    // Expected writes, in order
cpu_pkg::byte_t exp_data[$];
int             exp_cycle[$];

localparam cpu_pkg::byte_t ALU_IMM_OPS [8] = '{cpu_pkg::OPC_LDA_IMM, cpu_pkg::OPC_LDX_IMM,
    cpu_pkg::OPC_ADC_IMM, cpu_pkg::OPC_SBC_IMM, cpu_pkg::OPC_AND_IMM, cpu_pkg::OPC_ORA_IMM,
    cpu_pkg::OPC_EOR_IMM, cpu_pkg::OPC_CMP_IMM};
localparam cpu_pkg::byte_t ALU_ZP_OPS [8] = '{cpu_pkg::OPC_LDA_ZP, cpu_pkg::OPC_LDX_ZP,
    cpu_pkg::OPC_ADC_ZP, cpu_pkg::OPC_SBC_ZP, cpu_pkg::OPC_AND_ZP, cpu_pkg::OPC_ORA_ZP,
    cpu_pkg::OPC_EOR_ZP, cpu_pkg::OPC_CMP_ZP};
localparam cpu_pkg::byte_t IMPL_OPS [8] = '{cpu_pkg::OPC_TAX, cpu_pkg::OPC_TXA,
    cpu_pkg::OPC_INX, cpu_pkg::OPC_DEX, cpu_pkg::OPC_CLC, cpu_pkg::OPC_SEC,
    cpu_pkg::OPC_INX, cpu_pkg::OPC_DEX};        // Counters twice as likely
localparam cpu_pkg::byte_t BRA_OPS [8] = '{cpu_pkg::OPC_BPL, cpu_pkg::OPC_BMI,
    cpu_pkg::OPC_BCC, cpu_pkg::OPC_BCS, cpu_pkg::OPC_BNE, cpu_pkg::OPC_BEQ,
    cpu_pkg::OPC_BNE, cpu_pkg::OPC_BEQ};

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
endfunction

function automatic int rand_bits(int nbits);
    int r;
    r = 0;
    for (int i = 0; i < nbits; i++)
        r = (r << 1) | int'(lfsr_bit());        // One step per bit
    return r;
endfunction

function automatic cpu_pkg::byte_t fill_byte(cpu_pkg::addr_t a);
    return a[7:0] ^ {a[11:8], a[15:12]} ^ 8'h3C;   // All 16 address bits
endfunction

function automatic logic in_zp_list(cpu_pkg::byte_t op);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < 8; i++)
        if (ALU_ZP_OPS[i] == op)
            hit = 1'b1;
    return hit;
endfunction

task automatic emit(cpu_pkg::byte_t b);
    mem[gen_pc] = b;
    gen_pc = gen_pc + 16'd1;
endtask

task automatic emit_store();
    emit((rand_bits(1) == 1) ? cpu_pkg::OPC_STA_ZP : cpu_pkg::OPC_STX_ZP);
    emit(8'(rand_bits(4)));                     // Low 16 bytes of zero page
endtask

task automatic gen_program();
    logic [2:0]     kind;
    logic [2:0]     sel;
    cpu_pkg::addr_t loop_pc;
    gen_pc = RESET_PC;
    for (int i = 0; i < 60; i++) begin
        kind = 3'(rand_bits(3));
        sel  = 3'(rand_bits(3));
        if ((gen_pc[7:0] == 8'hF9 || gen_pc[7:0] == 8'hFA) && kind == 3'd7)
            kind = 3'd5;                        // Keep from stepping past the crossing slot
        if (gen_pc[7:0] == 8'hFB || gen_pc[7:0] == 8'hFC) begin
            emit(cpu_pkg::OPC_SEC);             // Carry set, BCS below is taken
            kind = 3'd7;
            sel  = 3'd3;                        // BCS, target lands in next page
        end
        case (kind)
            3'd0, 3'd1, 3'd2: begin
                if (rand_bits(1) == 1) begin
                    emit(ALU_ZP_OPS[sel]);
                    emit(8'(rand_bits(4)));
                end else begin
                    emit(ALU_IMM_OPS[sel]);
                    emit(8'(rand_bits(8)));
                end
            end
            3'd3, 3'd4: emit_store();
            3'd5, 3'd6: emit(IMPL_OPS[sel]);
            default: begin
                emit(BRA_OPS[sel]);
                emit(8'h02);                    // Skip the store below
                emit_store();
            end
        endcase
    end
    loop_pc = gen_pc;
    emit(cpu_pkg::OPC_JMP_ABS);                 // Park on itself
    emit(loop_pc[7:0]);
    emit(loop_pc[15:8]);
endtask

function automatic void set_nz(cpu_pkg::byte_t r);
    m_n = r[7];
    m_z = (r == 8'h00);
endfunction

// Instruction-level model, cycle of each DECODE from the timing table
task automatic run_model();
    cpu_pkg::addr_t pc;
    cpu_pkg::addr_t next_pc;
    cpu_pkg::byte_t op;
    cpu_pkg::byte_t opnd;
    cpu_pkg::byte_t m;
    logic [8:0]     sum;
    logic           taken;
    logic           done;
    int             cyc;
    int             cost;
    for (int i = 0; i < 256; i++)
        zp_mem[i] = fill_byte({cpu_pkg::ZERO_PAGE, 8'(i)});
    m_a = 8'h00;
    m_x = 8'h00;
    {m_n, m_v, m_z, m_c} = 4'b0000;
    pc   = RESET_PC;
    cyc  = 1;                                   // Cycle 0 fetches the first opcode
    done = 1'b0;
    for (int step = 0; step < 500 && !done; step++) begin
        op      = mem[pc];
        opnd    = mem[pc + 16'd1];
        m       = in_zp_list(op) ? zp_mem[opnd] : opnd;
        cost    = in_zp_list(op) ? 3 : 2;
        next_pc = pc + 16'd2;
        taken   = 1'b0;
        case (op)
            cpu_pkg::OPC_LDA_IMM, cpu_pkg::OPC_LDA_ZP: begin
                m_a = m;
                set_nz(m_a);
            end
            cpu_pkg::OPC_LDX_IMM, cpu_pkg::OPC_LDX_ZP: begin
                m_x = m;
                set_nz(m_x);
            end
            cpu_pkg::OPC_ADC_IMM, cpu_pkg::OPC_ADC_ZP: begin
                sum = {1'b0, m_a} + {1'b0, m} + {8'd0, m_c};
                m_v = (m_a[7] == m[7]) && (sum[7] != m_a[7]);   // Same signs in, other out
                m_c = sum[8];
                m_a = sum[7:0];
                set_nz(m_a);
            end
            cpu_pkg::OPC_SBC_IMM, cpu_pkg::OPC_SBC_ZP: begin
                sum = {1'b0, m_a} + {1'b0, ~m} + {8'd0, m_c};   // Carry is not-borrow
                m_v = (m_a[7] != m[7]) && (sum[7] != m_a[7]);
                m_c = sum[8];
                m_a = sum[7:0];
                set_nz(m_a);
            end
            cpu_pkg::OPC_AND_IMM, cpu_pkg::OPC_AND_ZP: begin
                m_a = m_a & m;
                set_nz(m_a);
            end
            cpu_pkg::OPC_ORA_IMM, cpu_pkg::OPC_ORA_ZP: begin
                m_a = m_a | m;
                set_nz(m_a);
            end
            cpu_pkg::OPC_EOR_IMM, cpu_pkg::OPC_EOR_ZP: begin
                m_a = m_a ^ m;
                set_nz(m_a);
            end
            cpu_pkg::OPC_CMP_IMM, cpu_pkg::OPC_CMP_ZP: begin
                m_c = m_a >= m;
                set_nz(8'(m_a - m));
            end
            cpu_pkg::OPC_STA_ZP, cpu_pkg::OPC_STX_ZP: begin
                m = (op == cpu_pkg::OPC_STX_ZP) ? m_x : m_a;
                exp_addr.push_back({cpu_pkg::ZERO_PAGE, opnd});
                exp_data.push_back(m);
                exp_cycle.push_back(cyc + 1);   // Write in second cycle
                zp_mem[opnd] = m;
                cost = 3;
            end
            cpu_pkg::OPC_TAX: begin
                m_x = m_a;
                set_nz(m_x);
                next_pc = pc + 16'd1;
            end
            cpu_pkg::OPC_TXA: begin
                m_a = m_x;
                set_nz(m_a);
                next_pc = pc + 16'd1;
            end
            cpu_pkg::OPC_INX, cpu_pkg::OPC_DEX: begin
                m_x = (op == cpu_pkg::OPC_INX) ? m_x + 8'd1 : m_x - 8'd1;
                set_nz(m_x);
                next_pc = pc + 16'd1;
            end
            cpu_pkg::OPC_CLC, cpu_pkg::OPC_SEC: begin
                m_c = (op == cpu_pkg::OPC_SEC);
                next_pc = pc + 16'd1;
            end
            cpu_pkg::OPC_BPL, cpu_pkg::OPC_BMI, cpu_pkg::OPC_BCC,
            cpu_pkg::OPC_BCS, cpu_pkg::OPC_BNE, cpu_pkg::OPC_BEQ: begin
                case (op)
                    cpu_pkg::OPC_BPL: taken = !m_n;
                    cpu_pkg::OPC_BMI: taken = m_n;
                    cpu_pkg::OPC_BCC: taken = !m_c;
                    cpu_pkg::OPC_BCS: taken = m_c;
                    cpu_pkg::OPC_BNE: taken = !m_z;
                    default:          taken = m_z;
                endcase
                if (taken) begin
                    pc   = next_pc;
                    next_pc = pc + {{8{opnd[7]}}, opnd};
                    cost = (next_pc[15:8] != pc[15:8]) ? 4 : 3;   // Page fixup cycle
                end
            end
            cpu_pkg::OPC_JMP_ABS: begin
                next_pc = {mem[pc + 16'd2], opnd};
                done    = (next_pc == pc);
                cost    = 3;
            end
            default: next_pc = pc + 16'd1;      // Two-cycle NOP
        endcase
        pc  = next_pc;
        cyc = cyc + cost;
    end
endtask

`endif

// File: sim/tb_top.sv
module tb_top;

    localparam cpu_pkg::addr_t RESET_PC = 16'h02C0;
    localparam int WRITE_TIMEOUT = 3000;        // Cycles to see every expected write
    localparam int QUIET_CYCLES  = 300;         // Window after the final JMP

    logic           clk;
    logic           reset;
    cpu_pkg::addr_t addr;
    cpu_pkg::byte_t din;
    cpu_pkg::byte_t dout;
    logic           we;

    cpu_pkg::byte_t mem [0:65535];
    cpu_pkg::addr_t bus_addr = RESET_PC;        // Bus as seen mid-cycle
    cpu_pkg::byte_t bus_dout = 8'h00;
    logic           bus_we = 1'b0;
    int             cycle = -1;                 // 0 is first cycle out of reset
    int             wr_idx = 0;

    `include "tb_model.svh"

    cpu_core #(.RESET_PC(RESET_PC)) u_cpu_core (
        .clk(clk), .reset(reset), .addr(addr), .din(din), .dout(dout), .we(we)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1, "stopped at first error");
    endtask

    task automatic fail_plain(string why);
        $display("%s", why);
        abort_run();
    endtask

    task automatic check_addr(string name, cpu_pkg::addr_t got, cpu_pkg::addr_t exp);
        if (got !== exp) begin
            $display("MISMATCH time %0t %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_byte(string name, cpu_pkg::byte_t got, cpu_pkg::byte_t exp);
        if (got !== exp) begin
            $display("MISMATCH time %0t %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_int(string name, int got, int exp);
        if (got != exp) begin
            $display("MISMATCH time %0t %s got %0d expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    // Synchronous read, data one edge after the address
    always @(posedge clk) begin
        if (bus_we)
            mem[bus_addr] = bus_dout;
        #1 din = mem[bus_addr];
    end

    // Sample bus mid-cycle and check writes against the model
    always @(negedge clk) begin
        bus_addr = addr;
        bus_dout = dout;
        bus_we   = we;
        if (!reset) begin
            cycle = cycle + 1;
            if (cycle == 0) begin
                check_addr("addr", addr, RESET_PC);
                check_int("we", (we === 1'b0) ? 0 : 1, 0);
            end
            if (we) begin
                if (wr_idx >= exp_addr.size())
                    fail_plain($sformatf("Unexpected write to %h at cycle %0d", addr, cycle));
                check_addr("addr", addr, exp_addr[wr_idx]);
                check_byte("dout", dout, exp_data[wr_idx]);
                check_int("write cycle", cycle, exp_cycle[wr_idx]);
                wr_idx = wr_idx + 1;
            end
        end
    end

    initial begin
        int waited;
        reset = 1'b1;
        din   = 8'h00;
        for (int i = 0; i < 65536; i++)
            mem[i] = fill_byte(16'(i));
        gen_program();
        run_model();
        if (exp_addr.size() == 0)
            fail_plain("Generated program makes no writes");
        repeat (10) @(posedge clk);
        #1 reset = 1'b0;
        waited = 0;
        while (wr_idx < exp_addr.size()) begin
            if (waited >= WRITE_TIMEOUT)
                fail_plain($sformatf("Timed out with %0d of %0d writes seen",
                                     wr_idx, exp_addr.size()));
            @(negedge clk);
            waited = waited + 1;
        end
        waited = 0;
        while (waited < QUIET_CYCLES) begin     // Monitor flags any stray write
            @(negedge clk);
            waited = waited + 1;
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: src.f
+incdir+sim
rtl/cpu_pkg.sv
rtl/cpu_decode.sv
rtl/cpu_alu.sv
rtl/cpu_regs.sv
rtl/cpu_sequencer.sv
rtl/cpu_core.sv
sim/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Finished with no errors

SRCS := $(shell grep -v '^+' src.f)
HDRS := $(wildcard sim/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) src.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f src.f

run: $(BIN)
	@out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
